// ==== sys_ctrl_pkg.sv ====
`default_nettype none

package sys_ctrl_pkg;

  // bus and record widths
  typedef logic [31:0] word_t;      // bus data word
  typedef logic [4:0]  pid_t;       // process id
  typedef logic [23:0] err_addr_t;  // pc value kept with an error
  typedef logic [7:0]  err_no_t;    // error number
  typedef logic [7:0]  err_vec_t;   // hardware error lines

  // control/status byte
  //   [0]   reset without restart
  //   [1]   reset request, held while the sequence runs
  //   [2]   error handling in progress
  //   [7:3] spare, storable
  typedef logic [7:0]  scs_t;

  localparam int SCS_RST_REQ  = 1;  // reset request bit
  localparam int SCS_HANDLING = 2;  // handling flag bit

  // line n reports ERR_BASE + n
  localparam err_no_t ERR_BASE = 8'h10;

  // length of the system reset hold, short for simulation
  localparam int RST_CYCLES = 16;
  localparam int RST_CNT_W  = $clog2(RST_CYCLES + 1);

  typedef logic [RST_CNT_W-1:0] rst_cnt_t;  // reset hold counter

  // reset sequencer states
  typedef enum logic {
    IDLE,  // waiting for a request
    HOLD   // system reset asserted
  } seq_state_t;

endpackage

`default_nettype wire

// ==== err_capture.sv ====
`timescale 1ns/1ns
`default_nettype none

module err_capture (
  input  wire                        clk,
  input  wire                        reset,
  input  wire sys_ctrl_pkg::err_vec_t  err_sig,       // hardware error lines
  input  wire sys_ctrl_pkg::err_addr_t err_addr,      // current pc
  input  wire                        wr_err,        // trap write strobe
  input  wire                        wr_scs,        // scs write strobe
  input  wire                        busy,          // reset request pending
  input  wire                        handling,      // error being handled
  input  wire sys_ctrl_pkg::word_t     data_in,
  output logic                       raise,         // one pulse per recorded error
  output sys_ctrl_pkg::err_no_t      err_no,
  output sys_ctrl_pkg::err_addr_t    err_rec_addr
);

  import sys_ctrl_pkg::*;

  err_vec_t  err_q;     // sampled lines
  err_vec_t  err_q2;    // previous sample
  err_vec_t  edges;     // rising edges seen this cycle
  err_vec_t  pend;      // edges not yet served
  err_no_t   line_no;   // number of lowest pending line
  err_no_t   rec_no;
  err_addr_t rec_addr;
  logic      idle;
  logic      record;

  assign edges = err_q & ~err_q2;

  // no capture while a reset is requested, a raise is in flight
  // or software is rewriting scs
  assign idle = ~busy & ~raise & ~wr_scs;

  // lowest pending line wins
  always_comb begin
    line_no = ERR_BASE;
    for (int i = 7; i >= 0; i--) begin
      if (pend[i]) begin
        line_no = ERR_BASE + err_no_t'(i);
      end
    end
  end

  always_comb begin
    record   = 1'b0;
    rec_no   = line_no;
    rec_addr = err_addr;
    if (idle) begin
      if (pend[0]) begin                 // line 0 ignores the handling flag
        record = 1'b1;
      end else if (!handling) begin
        if (wr_err) begin                // software trap
          record   = 1'b1;
          rec_no   = data_in[7:0];
          rec_addr = data_in[31:8];
        end else if (|pend) begin        // other hardware lines
          record = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset) begin
      err_q        <= '0;
      err_q2       <= '0;
      pend         <= '0;
      raise        <= 1'b0;
      err_no       <= '0;
      err_rec_addr <= '0;
    end else begin
      err_q  <= err_sig;
      err_q2 <= err_q;
      raise  <= record;
      if (record) begin
        pend         <= '0;              // one error at a time
        err_no       <= rec_no;
        err_rec_addr <= rec_addr;
      end else begin
        pend <= pend | edges;
      end
    end
  end

endmodule

`default_nettype wire

// ==== reset_seq.sv ====
`timescale 1ns/1ns
`default_nettype none

module reset_seq (
  input  wire  clk,
  input  wire  reset,
  input  wire  rst_req,   // scs reset request bit
  output logic seq_rst,   // system reset from the sequence
  output logic done       // last hold cycle
);

  import sys_ctrl_pkg::*;

  seq_state_t state;
  rst_cnt_t   cnt;        // hold cycles elapsed
  logic       last;

  assign last = (cnt == rst_cnt_t'(RST_CYCLES));

  always_ff @(posedge clk) begin
    if (!reset) begin
      state <= IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        IDLE: begin
          cnt <= '0;
          if (rst_req) begin
            state <= HOLD;
          end
        end
        HOLD: begin
          if (last) begin
            state <= IDLE;               // request bit drops on this edge too
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // held for RST_CYCLES+1 cycles
  assign seq_rst = (state == HOLD);
  assign done    = seq_rst & last;

endmodule

`default_nettype wire

// ==== scs_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module scs_regs (
  input  wire                        clk,
  input  wire                        reset,
  input  wire                        stb,
  input  wire                        we,
  input  wire                        addr,
  input  wire sys_ctrl_pkg::word_t     data_in,
  input  wire                        raise,          // error recorded
  input  wire                        done,           // reset sequence ends
  input  wire sys_ctrl_pkg::err_no_t   err_no,
  input  wire sys_ctrl_pkg::err_addr_t err_rec_addr,
  output sys_ctrl_pkg::word_t        data_out,
  output logic                       ack,
  output logic                       wr_err,         // trap write
  output logic                       wr_scs,         // scs write
  output logic                       busy,
  output logic                       handling,
  output logic                       rst_req,
  output sys_ctrl_pkg::pid_t         cp_pid
);

  import sys_ctrl_pkg::*;

  scs_t scs_q;       // control and status
  pid_t cp_pid_q;    // current process
  pid_t err_pid_q;   // process that failed
  logic rd_scs;
  logic rd_err;

  // writes are dropped while a reset is requested
  assign wr_scs = stb & we & ~addr & ~busy;
  assign wr_err = stb & we & addr & ~busy;
  assign rd_scs = stb & ~we & ~addr;
  assign rd_err = stb & ~we & addr;

  assign ack = stb;  // single cycle, never stalled

  always_ff @(posedge clk) begin
    if (!reset) begin
      scs_q     <= '0;
      cp_pid_q  <= '0;
      err_pid_q <= '0;
    end else begin
      if (raise) begin
        scs_q[SCS_RST_REQ]  <= 1'b1;     // start reset sequence
        scs_q[SCS_HANDLING] <= 1'b1;     // cleared by software
      end else if (wr_scs) begin
        scs_q     <= data_in[7:0];
        cp_pid_q  <= data_in[12:8];
        err_pid_q <= data_in[17:13];
      end else if (done) begin
        scs_q[SCS_RST_REQ] <= 1'b0;
      end
    end
  end

  assign busy     = scs_q[SCS_RST_REQ];
  assign rst_req  = scs_q[SCS_RST_REQ];
  assign handling = scs_q[SCS_HANDLING];
  assign cp_pid   = cp_pid_q;

  // read word, zero when idle
  always_comb begin
    if (rd_scs) begin
      data_out = {14'b0, err_pid_q, cp_pid_q, scs_q};
    end else if (rd_err) begin
      data_out = {err_rec_addr, err_no};
    end else begin
      data_out = '0;
    end
  end

endmodule

`default_nettype wire

// ==== sys_ctrl_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sys_ctrl_top (
  input  wire                        clk,
  input  wire                        reset,      // cold restart
  input  wire                        stb,
  input  wire                        we,
  input  wire                        addr,
  input  wire sys_ctrl_pkg::word_t     data_in,
  input  wire sys_ctrl_pkg::err_vec_t  err_sig,
  input  wire sys_ctrl_pkg::err_addr_t err_addr,
  output sys_ctrl_pkg::word_t        data_out,
  output logic                       ack,
  output logic                       sys_rst,
  output logic                       sys_rst_n,
  output sys_ctrl_pkg::pid_t         cp_pid
);

  import sys_ctrl_pkg::*;

  logic      wr_err;
  logic      wr_scs;
  logic      busy;
  logic      handling;
  logic      raise;
  logic      rst_req;
  logic      done;
  logic      seq_rst;
  err_no_t   err_no;
  err_addr_t err_rec_addr;

  err_capture i_err_capture (
    .clk          (clk),
    .reset        (reset),
    .err_sig      (err_sig),
    .err_addr     (err_addr),
    .wr_err       (wr_err),
    .wr_scs       (wr_scs),
    .busy         (busy),
    .handling     (handling),
    .data_in      (data_in),
    .raise        (raise),
    .err_no       (err_no),
    .err_rec_addr (err_rec_addr)
  );

  reset_seq i_reset_seq (
    .clk     (clk),
    .reset   (reset),
    .rst_req (rst_req),
    .seq_rst (seq_rst),
    .done    (done)
  );

  scs_regs i_scs_regs (
    .clk          (clk),
    .reset        (reset),
    .stb          (stb),
    .we           (we),
    .addr         (addr),
    .data_in      (data_in),
    .raise        (raise),
    .done         (done),
    .err_no       (err_no),
    .err_rec_addr (err_rec_addr),
    .data_out     (data_out),
    .ack          (ack),
    .wr_err       (wr_err),
    .wr_scs       (wr_scs),
    .busy         (busy),
    .handling     (handling),
    .rst_req      (rst_req),
    .cp_pid       (cp_pid)
  );

  assign sys_rst   = ~reset | seq_rst;  // cold or sequenced
  assign sys_rst_n = ~sys_rst;

endmodule

`default_nettype wire

// ==== sys_ctrl_sva.sv ====
`timescale 1ns/1ns
`default_nettype none

module sys_ctrl_sva (
  input wire                       clk,
  input wire                       reset,
  input wire                       stb,
  input wire                       we,
  input wire                       addr,
  input wire sys_ctrl_pkg::word_t  data_out,
  input wire                       ack,
  input wire                       sys_rst,
  input wire                       sys_rst_n,
  input wire sys_ctrl_pkg::pid_t   cp_pid
);

  import sys_ctrl_pkg::*;

  int unsigned fails = 0;  // assertion failures so far

  // ack follows the strobe in the same cycle
  ack_is_stb: assert property (@(posedge clk) ack == stb)
    else begin
      fails++;
      $error("ack differs from stb");
    end

  rst_n_inverse: assert property (@(posedge clk) sys_rst_n == !sys_rst)
    else begin
      fails++;
      $error("sys_rst_n is not the inverse of sys_rst");
    end

  // sequenced reset is held for RST_CYCLES+1 cycles
  rst_pulse_len: assert property (@(posedge clk) disable iff (!reset)
      $rose(sys_rst) |-> sys_rst [* RST_CYCLES + 1] ##1 !sys_rst)
    else begin
      fails++;
      $error("system reset pulse has the wrong length");
    end

  // read word of addr 0 is err pid, cp pid and scs, upper bits zero
  scs_read_layout: assert property (@(posedge clk) disable iff (!reset)
      (stb && !we && !addr) |-> (data_out[31:18] == '0 && data_out[12:8] == cp_pid))
    else begin
      fails++;
      $error("scs read word does not match the register layout");
    end

  // bus is quiet when no read is active
  idle_bus_zero: assert property (@(posedge clk) disable iff (!reset)
      !(stb && !we) |-> data_out == '0)
    else begin
      fails++;
      $error("data_out is not zero outside a read");
    end

endmodule

bind sys_ctrl_top sys_ctrl_sva i_sva (.*);

`default_nettype wire

// ==== tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
  input  wire  restart,   // cold restart request from the testbench
  output logic clk,
  output logic reset
);

  logic por_done;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  initial begin
    por_done = 1'b0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    por_done = 1'b1;        // released after 2 cycles
  end

  assign reset = por_done & ~restart;

endmodule

`default_nettype wire

// ==== tb_sys_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_sys_ctrl;

  import sys_ctrl_pkg::*;

  // cycle budget per test, summed for the watchdog
  localparam int T1_CYCLES   = 40;
  localparam int T2_CYCLES   = 60;
  localparam int T3_CYCLES   = 90;
  localparam int T4_CYCLES   = 110;
  localparam int T5_CYCLES   = 110;
  localparam int T6_CYCLES   = 40;
  localparam int WATCHDOG_NS = (T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES
                                + T5_CYCLES + T6_CYCLES + 200) * 8;

  logic      clk;
  logic      reset;
  logic      restart;
  logic      stb;
  logic      we;
  logic      addr;
  word_t     data_in;
  err_vec_t  err_sig;
  err_addr_t err_addr;
  word_t     data_out;
  logic      ack;
  logic      sys_rst;
  logic      sys_rst_n;
  pid_t      cp_pid;

  integer    seed;
  integer    errors;
  word_t     rnd;
  word_t     rd;

  // expected register contents
  scs_t      exp_scs;
  pid_t      exp_cp;
  pid_t      exp_err_pid;
  err_no_t   exp_no;
  err_addr_t exp_addr;

  tb_clock i_clock (
    .restart (restart),
    .clk     (clk),
    .reset   (reset)
  );

  sys_ctrl_top i_dut (
    .clk       (clk),
    .reset     (reset),
    .stb       (stb),
    .we        (we),
    .addr      (addr),
    .data_in   (data_in),
    .err_sig   (err_sig),
    .err_addr  (err_addr),
    .data_out  (data_out),
    .ack       (ack),
    .sys_rst   (sys_rst),
    .sys_rst_n (sys_rst_n),
    .cp_pid    (cp_pid)
  );

  task automatic check_word(input string what, input word_t got, input word_t exp);
    assert (got == exp) else begin
      errors = errors + 1;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Finished with errors");
      $fatal(1);
    end
  endtask

  task automatic bus_write(input logic a, input word_t d);
    @(negedge clk);
    stb     = 1'b1;
    we      = 1'b1;
    addr    = a;
    data_in = d;
    @(negedge clk);
    stb     = 1'b0;
    we      = 1'b0;
    data_in = '0;
  endtask

  task automatic bus_read(input logic a, output word_t d);
    @(negedge clk);
    stb  = 1'b1;
    we   = 1'b0;
    addr = a;
    #1 d = data_out;         // combinational read, stable mid cycle
    @(negedge clk);
    stb  = 1'b0;
  endtask

  task automatic write_scs(input word_t d);
    bus_write(1'b0, d);
    exp_scs     = d[7:0];
    exp_cp      = d[12:8];
    exp_err_pid = d[17:13];
  endtask

  task automatic check_regs();
    bus_read(1'b0, rd);
    check_word("scs word", rd, {14'b0, exp_err_pid, exp_cp, exp_scs});
    bus_read(1'b1, rd);
    check_word("error word", rd, {exp_addr, exp_no});
    check_word("cp_pid", word_t'(cp_pid), word_t'(exp_cp));
  endtask

  task automatic wait_seq_start();
    int n;
    n = 0;
    while (sys_rst !== 1'b1) begin
      @(negedge clk);
      n = n + 1;
      if (n > 20) begin
        $display("no system reset sequence started after the error");
        $display("Finished with errors");
        $fatal(1);
      end
    end
  endtask

  task automatic wait_seq_end();
    int n;
    n = 0;
    while (sys_rst !== 1'b0) begin
      @(negedge clk);
      n = n + 1;
      if (n > RST_CYCLES + 10) begin
        $display("system reset sequence did not end");
        $display("Finished with errors");
        $fatal(1);
      end
    end
  endtask

  // an error was recorded, so handling stays set after the sequence
  task automatic expect_sequence();
    wait_seq_start();
    wait_seq_end();
    exp_scs[SCS_HANDLING] = 1'b1;
  endtask

  task automatic expect_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_word("sys_rst while idle", word_t'(sys_rst), '0);
    end
  endtask

  task automatic pulse_lines(input err_vec_t v);
    @(negedge clk);
    err_sig = v;
    repeat (2) @(negedge clk);
    err_sig = '0;
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the tests finished");
    $display("Finished with errors");
    $fatal(1);
  end

  initial begin
    wait (i_dut.i_sva.fails != 0);
    $display("an assertion on the DUT ports failed");
    $display("Finished with errors");
    $fatal(1);
  end

  initial begin
    seed        = 32'haa27_65a2;
    errors      = 0;
    restart     = 1'b0;
    stb         = 1'b0;
    we          = 1'b0;
    addr        = 1'b0;
    data_in     = '0;
    err_sig     = '0;
    err_addr    = '0;
    exp_scs     = '0;
    exp_cp      = '0;
    exp_err_pid = '0;
    exp_no      = '0;
    exp_addr    = '0;

    wait (reset === 1'b1);
    @(negedge clk);
    check_regs();

    // 1: random scs and pid writes, request bit kept clear
    repeat (4) begin
      rnd = $random(seed);
      rnd[SCS_RST_REQ] = 1'b0;
      write_scs(rnd);
      check_regs();
    end

    // 2: software trap
    rnd = $random(seed);
    rnd[SCS_RST_REQ]  = 1'b0;
    rnd[SCS_HANDLING] = 1'b0;
    write_scs(rnd);
    rnd = $random(seed);
    bus_write(1'b1, rnd);
    exp_no   = rnd[7:0];
    exp_addr = rnd[31:8];
    expect_sequence();
    check_regs();

    // 3: lines 3 and 5 together, lowest wins
    write_scs({14'b0, exp_err_pid, exp_cp, 8'h01});
    rnd      = $random(seed);
    err_addr = rnd[23:0];
    pulse_lines(8'b0010_1000);
    exp_no   = ERR_BASE + 8'd3;
    exp_addr = err_addr;
    expect_sequence();
    check_regs();
    write_scs({14'b0, exp_err_pid, exp_cp, 8'h00});
    expect_quiet(12);     // line 5 was dropped with the pending vector
    check_regs();

    // 4: handling set blocks line 4 and traps but not line 0
    write_scs({14'b0, exp_err_pid, exp_cp, 8'h04});
    pulse_lines(8'b0001_0000);
    expect_quiet(10);
    rnd = $random(seed);
    bus_write(1'b1, rnd);
    expect_quiet(10);
    check_regs();
    rnd      = $random(seed);
    err_addr = rnd[23:0];
    pulse_lines(8'b0000_0001);
    exp_no   = ERR_BASE;
    exp_addr = err_addr;
    expect_sequence();
    check_regs();

    // 5: writes ignored during a sequence
    rnd      = $random(seed);
    err_addr = rnd[23:0];
    pulse_lines(8'b0000_0001);
    exp_addr = err_addr;
    wait_seq_start();
    rnd = $random(seed);
    bus_write(1'b0, rnd);
    rnd = $random(seed);
    bus_write(1'b1, rnd);
    wait_seq_end();
    check_regs();
    write_scs({14'b0, exp_err_pid, exp_cp, 8'h00});
    rnd      = $random(seed);
    err_addr = rnd[23:0];
    pulse_lines(8'b0000_0100);
    exp_no   = ERR_BASE + 8'd2;
    exp_addr = err_addr;
    expect_sequence();
    check_regs();

    // 6: cold restart clears everything
    rnd = $random(seed);
    rnd[SCS_RST_REQ] = 1'b0;
    write_scs(rnd);
    @(negedge clk);
    restart = 1'b1;
    repeat (2) @(negedge clk);
    restart     = 1'b0;
    exp_scs     = '0;
    exp_cp      = '0;
    exp_err_pid = '0;
    exp_no      = '0;
    exp_addr    = '0;
    @(negedge clk);
    check_regs();
    expect_quiet(4);

    if (errors == 0 && i_dut.i_sva.fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
sys_ctrl_pkg.sv
err_capture.sv
reset_seq.sv
scs_regs.sv
sys_ctrl_top.sv
sys_ctrl_sva.sv
tb_clock.sv
tb_sys_ctrl.sv

// ==== Makefile ====
TOP = tb_sys_ctrl
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
	  echo "TEST FAILED"; exit 1; \
	elif ! grep -q "Finished with no errors" $(LOG); then \
	  echo "TEST FAILED"; exit 1; \
	else \
	  echo "TEST PASSED"; \
	fi

clean:
	rm -rf obj_dir $(LOG)
